// ==== design/tetris_pkg.sv ====
`default_nettype none

package tetris_pkg;

  // playfield geometry
  localparam int num_rows  = 22;
  localparam int num_cols  = 10;
  localparam int cell_bits = 3;

  typedef logic [num_cols-1:0][cell_bits-1:0] row_t;
  typedef logic [4:0] row_addr_t;
  typedef logic signed [4:0] col_t;
  typedef logic [1:0] rot_t;

  // spawn order
  typedef enum logic [2:0] {
    PIECE_I, PIECE_O, PIECE_T, PIECE_S, PIECE_Z, PIECE_J, PIECE_L
  } piece_t;

  typedef enum logic [2:0] {
    RIGHT, LEFT, ROR, ROL, DOWN, NONE
  } move_t;

  typedef enum logic [2:0] {
    IDLE, SPAWN, READY, CHECK, LOCK, CLEAR, GAME_OVER
  } state_t;

  // one row access on the shared memory
  typedef struct packed {
    logic      req;
    logic      we;
    row_addr_t addr;
    row_t      wdata;
  } row_req_t;

  //////////////////////////////////////////////////////////////////////
  // shape table, bit index is box row * 4 + box column
  //////////////////////////////////////////////////////////////////////

  // clockwise quarter turn of the upper left 3x3 corner
  function automatic logic [15:0] turn3_cw(input logic [15:0] m);
    logic [15:0] res;
    res = '0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        res[r*4+c] = m[(2-c)*4+r];
      end
    end
    return res;
  endfunction

  function automatic logic [15:0] piece_shape(input piece_t p, input rot_t r);
    logic [15:0] m;
    case (p)
      PIECE_T: m = 16'h0072;
      PIECE_S: m = 16'h0036;
      PIECE_Z: m = 16'h0063;
      PIECE_J: m = 16'h0071;
      default: m = 16'h0074;
    endcase
    if (p == PIECE_I) begin
      // the I bar turns in the full 4x4 box
      case (r)
        2'd0:    m = 16'h00F0;
        2'd1:    m = 16'h4444;
        2'd2:    m = 16'h0F00;
        default: m = 16'h2222;
      endcase
    end else if (p == PIECE_O) begin
      m = 16'h0066;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (i < r) begin
          m = turn3_cw(m);
        end
      end
    end
    return m;
  endfunction

  function automatic logic [cell_bits-1:0] piece_color(input piece_t p);
    return cell_bits'(p) + cell_bits'(1);
  endfunction

  // field columns covered by one box row, cells past a wall dropped
  function automatic logic [num_cols-1:0] col_mask(input logic [3:0] bits, input col_t col);
    logic [num_cols-1:0] m;
    col_t                c;
    m = '0;
    for (int j = 0; j < 4; j++) begin
      c = col + col_t'(j);
      if (bits[j] && c >= 0 && c < num_cols) begin
        m[c[3:0]] = 1'b1;
      end
    end
    return m;
  endfunction

  // non-empty cells of a row
  function automatic logic [num_cols-1:0] filled(input row_t r);
    logic [num_cols-1:0] f;
    for (int c = 0; c < num_cols; c++) begin
      f[c] = |r[c];
    end
    return f;
  endfunction

endpackage

`default_nettype wire

// ==== design/playfield_mem.sv ====
`default_nettype none

module playfield_mem (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       clear_i,
  input  wire tetris_pkg::row_req_t req_i,
  output tetris_pkg::row_t          rd_data_o
);

  tetris_pkg::row_t mem [tetris_pkg::num_rows];

  // write port and whole-field clear
  always_ff @(posedge clk) begin
    if (clear_i) begin
      for (int r = 0; r < tetris_pkg::num_rows; r++) begin
        mem[r] <= '0;
      end
    end else if (req_i.req && req_i.we) begin
      mem[req_i.addr] <= req_i.wdata;
    end
  end

  // registered read, data one cycle after the grant
  always_ff @(posedge clk) begin
    if (req_i.req) begin
      rd_data_o <= mem[req_i.addr];
    end
  end

  // every requester stays inside the field
  a_addr_range: assert property (@(posedge clk) disable iff (rst)
    req_i.req |-> req_i.addr < tetris_pkg::num_rows);

endmodule

`default_nettype wire

// ==== design/row_arbiter.sv ====
`default_nettype none

module row_arbiter #(
  parameter int num_req = 4
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire tetris_pkg::row_req_t req_i [num_req],
  output logic [num_req-1:0]        gnt_o,
  output tetris_pkg::row_req_t      mem_req_o,
  input  wire tetris_pkg::row_t     mem_rd_i,
  output logic [num_req-1:0]        rd_valid_o,
  output tetris_pkg::row_t          rd_data_o
);

  // lowest index wins, scan from the top so it overrides
  always_comb begin
    gnt_o     = '0;
    mem_req_o = '0;
    for (int i = num_req - 1; i >= 0; i--) begin
      if (req_i[i].req) begin
        gnt_o     = '0;
        gnt_o[i]  = 1'b1;
        mem_req_o = req_i[i];
      end
    end
  end

  // read data comes back to the reader granted one cycle before
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_valid_o <= '0;
    end else if (mem_req_o.we) begin
      rd_valid_o <= '0;
    end else begin
      rd_valid_o <= gnt_o;
    end
  end

  assign rd_data_o = mem_rd_i;

  a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt_o));

  // a losing requester keeps its request up
  for (genvar g = 0; g < num_req; g++) begin : g_hold
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
      req_i[g].req && !gnt_o[g] |=> req_i[g].req);
  end

endmodule

`default_nettype wire

// ==== design/collision_checker.sv ====
`default_nettype none

module collision_checker (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        start_i,
  input  wire tetris_pkg::piece_t    piece_i,
  input  wire tetris_pkg::rot_t      rot_i,
  input  wire tetris_pkg::row_addr_t row_i,
  input  wire tetris_pkg::col_t      col_i,
  input  wire                        gnt_i,
  input  wire                        rd_valid_i,
  input  wire tetris_pkg::row_t      rd_data_i,
  output tetris_pkg::row_req_t       req_o,
  output logic                       done_o,
  output logic                       free_o
);

  typedef enum logic [1:0] {C_IDLE, C_RUN, C_WAIT} chk_state_t;

  chk_state_t                      state;
  logic [2:0]                      k;
  logic [15:0]                     shape;
  logic [3:0]                      bits;
  logic [tetris_pkg::num_cols-1:0] occ;
  tetris_pkg::row_addr_t           abs_row;
  logic                            wall;

  // current box row against walls and floor
  assign shape   = tetris_pkg::piece_shape(piece_i, rot_i);
  assign bits    = shape[k[1:0]*4 +: 4];
  assign occ     = tetris_pkg::col_mask(bits, col_i);
  assign abs_row = row_i + tetris_pkg::row_addr_t'(k);
  assign wall    = ($countones(occ) != $countones(bits)) ||
                   (abs_row >= tetris_pkg::num_rows);

  assign req_o = '{req:   state == C_RUN && k != 3'd4 && bits != '0 && !wall,
                   we:    1'b0,
                   addr:  abs_row,
                   wdata: '0};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= C_IDLE;
      k      <= '0;
      done_o <= 1'b0;
      free_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        C_IDLE: begin
          if (start_i) begin
            k      <= '0;
            free_o <= 1'b0;
            state  <= C_RUN;
          end
        end
        C_RUN: begin
          if (k == 3'd4) begin
            done_o <= 1'b1;
            free_o <= 1'b1;
            state  <= C_IDLE;
          end else if (bits == '0) begin
            k <= k + 3'd1;
          end else if (wall) begin
            // out of the field, stop here
            done_o <= 1'b1;
            state  <= C_IDLE;
          end else if (gnt_i) begin
            state <= C_WAIT;
          end
        end
        default: begin
          if (rd_valid_i) begin
            if (|(occ & tetris_pkg::filled(rd_data_i))) begin
              done_o <= 1'b1;
              state  <= C_IDLE;
            end else begin
              k     <= k + 3'd1;
              state <= C_RUN;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/piece_stamper.sv ====
`default_nettype none

module piece_stamper (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        start_i,
  input  wire tetris_pkg::piece_t    piece_i,
  input  wire tetris_pkg::rot_t      rot_i,
  input  wire tetris_pkg::row_addr_t row_i,
  input  wire tetris_pkg::col_t      col_i,
  input  wire                        gnt_i,
  input  wire                        rd_valid_i,
  input  wire tetris_pkg::row_t      rd_data_i,
  output tetris_pkg::row_req_t       req_o,
  output logic                       done_o
);

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_WAIT, S_WRITE} stamp_state_t;

  stamp_state_t                    state;
  logic [2:0]                      k;
  logic [15:0]                     shape;
  logic [3:0]                      bits;
  logic [tetris_pkg::num_cols-1:0] occ;
  tetris_pkg::row_t                merged;

  assign shape = tetris_pkg::piece_shape(piece_i, rot_i);
  assign bits  = shape[k[1:0]*4 +: 4];
  assign occ   = tetris_pkg::col_mask(bits, col_i);

  // read in RUN, write the merged row back in WRITE
  always_comb begin
    req_o      = '0;
    req_o.addr = row_i + tetris_pkg::row_addr_t'(k);
    if (state == S_RUN && k != 3'd4 && bits != '0) begin
      req_o.req = 1'b1;
    end
    if (state == S_WRITE) begin
      req_o.req   = 1'b1;
      req_o.we    = 1'b1;
      req_o.wdata = merged;
    end
  end

  // piece color over the old row
  always_ff @(posedge clk) begin
    if (state == S_WAIT && rd_valid_i) begin
      for (int c = 0; c < tetris_pkg::num_cols; c++) begin
        merged[c] <= occ[c] ? tetris_pkg::piece_color(piece_i) : rd_data_i[c];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= S_IDLE;
      k      <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_i) begin
            k     <= '0;
            state <= S_RUN;
          end
        end
        S_RUN: begin
          if (k == 3'd4) begin
            done_o <= 1'b1;
            state  <= S_IDLE;
          end else if (bits == '0) begin
            k <= k + 3'd1;
          end else if (gnt_i) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rd_valid_i) begin
            state <= S_WRITE;
          end
        end
        default: begin
          if (gnt_i) begin
            k     <= k + 3'd1;
            state <= S_RUN;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/line_clearer.sv ====
`default_nettype none

module line_clearer (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   start_i,
  input  wire                   gnt_i,
  input  wire                   rd_valid_i,
  input  wire tetris_pkg::row_t rd_data_i,
  output tetris_pkg::row_req_t  req_o,
  output logic                  done_o,
  output logic [2:0]            cleared_o
);

  typedef enum logic [2:0] {L_IDLE, L_READ, L_WAIT, L_WRITE, L_FILL} clr_state_t;

  clr_state_t            state;
  tetris_pkg::row_addr_t rd_ptr;
  tetris_pkg::row_addr_t wr_ptr;
  tetris_pkg::row_t      keep;

  always_comb begin
    req_o = '0;
    case (state)
      L_READ: begin
        req_o.req  = 1'b1;
        req_o.addr = rd_ptr;
      end
      L_WRITE: begin
        req_o.req   = 1'b1;
        req_o.we    = 1'b1;
        req_o.addr  = wr_ptr;
        req_o.wdata = keep;
      end
      L_FILL: begin
        // wr_ptr wraps to all ones past row 0
        req_o.req  = ~&wr_ptr;
        req_o.we   = 1'b1;
        req_o.addr = wr_ptr;
      end
      default: begin
        req_o = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == L_WAIT && rd_valid_i) begin
      keep <= rd_data_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= L_IDLE;
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      cleared_o <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        L_IDLE: begin
          if (start_i) begin
            rd_ptr    <= tetris_pkg::row_addr_t'(tetris_pkg::num_rows - 1);
            wr_ptr    <= tetris_pkg::row_addr_t'(tetris_pkg::num_rows - 1);
            cleared_o <= '0;
            state     <= L_READ;
          end
        end
        L_READ: begin
          if (gnt_i) begin
            state <= L_WAIT;
          end
        end
        L_WAIT: begin
          if (rd_valid_i) begin
            if (&(tetris_pkg::filled(rd_data_i))) begin
              // full row, drop it
              cleared_o <= cleared_o + 3'd1;
              rd_ptr    <= rd_ptr - 5'd1;
              state     <= (rd_ptr == '0) ? L_FILL : L_READ;
            end else begin
              state <= L_WRITE;
            end
          end
        end
        L_WRITE: begin
          if (gnt_i) begin
            wr_ptr <= wr_ptr - 5'd1;
            rd_ptr <= rd_ptr - 5'd1;
            state  <= (rd_ptr == '0) ? L_FILL : L_READ;
          end
        end
        default: begin
          if (&wr_ptr) begin
            done_o <= 1'b1;
            state  <= L_IDLE;
          end else if (gnt_i) begin
            wr_ptr <= wr_ptr - 5'd1;
          end
        end
      endcase
    end
  end

  // compaction only moves rows down
  a_ptr_order: assert property (@(posedge clk) disable iff (rst)
    state inside {L_READ, L_WAIT, L_WRITE} |-> wr_ptr >= rd_ptr);

endmodule

`default_nettype wire

// ==== design/game_ctrl.sv ====
`default_nettype none

module game_ctrl #(
  parameter int spawn_col = 3
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start_i,
  input  wire                     right_i,
  input  wire                     left_i,
  input  wire                     ror_i,
  input  wire                     rol_i,
  input  wire                     down_i,
  input  wire                     chk_done_i,
  input  wire                     chk_free_i,
  input  wire                     stamp_done_i,
  input  wire                     clr_done_i,
  input  wire [2:0]               cleared_i,
  output logic                    mem_clear_o,
  output logic                    chk_start_o,
  output logic                    stamp_start_o,
  output logic                    clr_start_o,
  output tetris_pkg::piece_t      cand_piece_o,
  output tetris_pkg::rot_t        cand_rot_o,
  output tetris_pkg::row_addr_t   cand_row_o,
  output tetris_pkg::col_t        cand_col_o,
  output tetris_pkg::piece_t      piece_o,
  output tetris_pkg::rot_t        rot_o,
  output tetris_pkg::row_addr_t   row_o,
  output tetris_pkg::col_t        col_o,
  output logic                    busy_o,
  output logic                    game_over_o,
  output logic [15:0]             lines_o
);

  tetris_pkg::state_t state;
  tetris_pkg::move_t  move;
  tetris_pkg::move_t  move_q;
  tetris_pkg::piece_t spawn_ctr;
  logic               do_spawn;

  // one strobe per cycle, right first
  always_comb begin
    if (right_i) begin
      move = tetris_pkg::RIGHT;
    end else if (left_i) begin
      move = tetris_pkg::LEFT;
    end else if (ror_i) begin
      move = tetris_pkg::ROR;
    end else if (rol_i) begin
      move = tetris_pkg::ROL;
    end else if (down_i) begin
      move = tetris_pkg::DOWN;
    end else begin
      move = tetris_pkg::NONE;
    end
  end

  assign busy_o   = !(state inside {tetris_pkg::IDLE, tetris_pkg::READY,
                                    tetris_pkg::GAME_OVER});
  assign do_spawn = ((state == tetris_pkg::IDLE || state == tetris_pkg::GAME_OVER) &&
                     start_i) || (state == tetris_pkg::CLEAR && clr_done_i);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state         <= tetris_pkg::IDLE;
      move_q        <= tetris_pkg::NONE;
      spawn_ctr     <= tetris_pkg::PIECE_I;
      cand_piece_o  <= tetris_pkg::PIECE_I;
      cand_rot_o    <= '0;
      cand_row_o    <= '0;
      cand_col_o    <= '0;
      piece_o       <= tetris_pkg::PIECE_I;
      rot_o         <= '0;
      row_o         <= '0;
      col_o         <= '0;
      lines_o       <= '0;
      game_over_o   <= 1'b0;
      mem_clear_o   <= 1'b0;
      chk_start_o   <= 1'b0;
      stamp_start_o <= 1'b0;
      clr_start_o   <= 1'b0;
    end else begin
      mem_clear_o   <= 1'b0;
      chk_start_o   <= 1'b0;
      stamp_start_o <= 1'b0;
      clr_start_o   <= 1'b0;

      // next piece from the cyclic counter, checked before it shows
      if (do_spawn) begin
        cand_piece_o <= spawn_ctr;
        cand_rot_o   <= '0;
        cand_row_o   <= '0;
        cand_col_o   <= tetris_pkg::col_t'(spawn_col);
        spawn_ctr    <= (spawn_ctr == tetris_pkg::PIECE_L) ? tetris_pkg::PIECE_I :
                        tetris_pkg::piece_t'(spawn_ctr + 3'd1);
        chk_start_o  <= 1'b1;
        state        <= tetris_pkg::SPAWN;
      end

      case (state)
        tetris_pkg::IDLE, tetris_pkg::GAME_OVER: begin
          if (start_i) begin
            mem_clear_o <= 1'b1;
            lines_o     <= '0;
            game_over_o <= 1'b0;
          end
        end
        tetris_pkg::SPAWN, tetris_pkg::CHECK: begin
          if (chk_done_i) begin
            if (chk_free_i) begin
              piece_o <= cand_piece_o;
              rot_o   <= cand_rot_o;
              row_o   <= cand_row_o;
              col_o   <= cand_col_o;
              state   <= tetris_pkg::READY;
            end else if (state == tetris_pkg::SPAWN) begin
              game_over_o <= 1'b1;
              state       <= tetris_pkg::GAME_OVER;
            end else if (move_q == tetris_pkg::DOWN) begin
              stamp_start_o <= 1'b1;
              state         <= tetris_pkg::LOCK;
            end else begin
              state <= tetris_pkg::READY;
            end
          end
        end
        tetris_pkg::READY: begin
          if (move != tetris_pkg::NONE) begin
            move_q       <= move;
            cand_piece_o <= piece_o;
            cand_rot_o   <= rot_o;
            cand_row_o   <= row_o;
            cand_col_o   <= col_o;
            case (move)
              tetris_pkg::RIGHT: cand_col_o <= col_o + tetris_pkg::col_t'(1);
              tetris_pkg::LEFT:  cand_col_o <= col_o - tetris_pkg::col_t'(1);
              tetris_pkg::ROR:   cand_rot_o <= rot_o + 2'd1;
              tetris_pkg::ROL:   cand_rot_o <= rot_o - 2'd1;
              default:           cand_row_o <= row_o + 5'd1;
            endcase
            chk_start_o <= 1'b1;
            state       <= tetris_pkg::CHECK;
          end
        end
        tetris_pkg::LOCK: begin
          if (stamp_done_i) begin
            clr_start_o <= 1'b1;
            state       <= tetris_pkg::CLEAR;
          end
        end
        tetris_pkg::CLEAR: begin
          if (clr_done_i) begin
            lines_o <= lines_o + 16'(cleared_i);
          end
        end
        default: begin
          state <= tetris_pkg::IDLE;
        end
      endcase
    end
  end

  // peers run one at a time
  a_one_start: assert property (@(posedge clk) disable iff (rst)
    $onehot0({chk_start_o, stamp_start_o, clr_start_o}));

endmodule

`default_nettype wire

// ==== design/tetris_top.sv ====
`default_nettype none

module tetris_top #(
  parameter int spawn_col = 3
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        start_i,
  input  wire                        right_i,
  input  wire                        left_i,
  input  wire                        ror_i,
  input  wire                        rol_i,
  input  wire                        down_i,
  input  wire                        disp_rd_i,
  input  wire tetris_pkg::row_addr_t disp_addr_i,
  output logic                       disp_valid_o,
  output tetris_pkg::row_t           disp_data_o,
  output tetris_pkg::piece_t         piece_o,
  output tetris_pkg::rot_t           rot_o,
  output tetris_pkg::row_addr_t      row_o,
  output tetris_pkg::col_t           col_o,
  output logic                       busy_o,
  output logic                       game_over_o,
  output logic [15:0]                lines_o
);

  localparam int num_req = 4;

  // requester index order gives the priority
  tetris_pkg::row_req_t  reqs [num_req];
  tetris_pkg::row_req_t  mem_req;
  tetris_pkg::row_t      mem_rd;
  tetris_pkg::row_t      rd_data;
  logic [num_req-1:0]    gnt;
  logic [num_req-1:0]    rd_valid;
  logic                  mem_clear;
  logic                  chk_start;
  logic                  chk_done;
  logic                  chk_free;
  logic                  stamp_start;
  logic                  stamp_done;
  logic                  clr_start;
  logic                  clr_done;
  logic [2:0]            cleared;
  tetris_pkg::piece_t    cand_piece;
  tetris_pkg::rot_t      cand_rot;
  tetris_pkg::row_addr_t cand_row;
  tetris_pkg::col_t      cand_col;

  assign reqs[3]      = '{req: disp_rd_i && !busy_o, we: 1'b0, addr: disp_addr_i, wdata: '0};
  assign disp_valid_o = rd_valid[3];
  assign disp_data_o  = rd_data;

  game_ctrl #(.spawn_col(spawn_col)) u_ctrl (
    .clk, .rst, .start_i, .right_i, .left_i, .ror_i, .rol_i, .down_i,
    .chk_done_i(chk_done), .chk_free_i(chk_free), .stamp_done_i(stamp_done),
    .clr_done_i(clr_done), .cleared_i(cleared), .mem_clear_o(mem_clear),
    .chk_start_o(chk_start), .stamp_start_o(stamp_start), .clr_start_o(clr_start),
    .cand_piece_o(cand_piece), .cand_rot_o(cand_rot), .cand_row_o(cand_row),
    .cand_col_o(cand_col), .piece_o, .rot_o, .row_o, .col_o, .busy_o, .game_over_o,
    .lines_o
  );

  collision_checker u_chk (
    .clk, .rst, .start_i(chk_start), .piece_i(cand_piece), .rot_i(cand_rot),
    .row_i(cand_row), .col_i(cand_col), .gnt_i(gnt[2]), .rd_valid_i(rd_valid[2]),
    .rd_data_i(rd_data), .req_o(reqs[2]), .done_o(chk_done), .free_o(chk_free)
  );

  piece_stamper u_stamp (
    .clk, .rst, .start_i(stamp_start), .piece_i(piece_o), .rot_i(rot_o), .row_i(row_o),
    .col_i(col_o), .gnt_i(gnt[1]), .rd_valid_i(rd_valid[1]), .rd_data_i(rd_data),
    .req_o(reqs[1]), .done_o(stamp_done)
  );

  line_clearer u_clr (
    .clk, .rst, .start_i(clr_start), .gnt_i(gnt[0]), .rd_valid_i(rd_valid[0]),
    .rd_data_i(rd_data), .req_o(reqs[0]), .done_o(clr_done), .cleared_o(cleared)
  );

  row_arbiter #(.num_req(num_req)) u_arb (
    .clk, .rst, .req_i(reqs), .gnt_o(gnt), .mem_req_o(mem_req), .mem_rd_i(mem_rd),
    .rd_valid_o(rd_valid), .rd_data_o(rd_data)
  );

  playfield_mem u_mem (
    .clk, .rst, .clear_i(mem_clear), .req_i(mem_req), .rd_data_o(mem_rd)
  );

endmodule

`default_nettype wire

// ==== verif/tetris_tb.sv ====
`default_nettype none

module tetris_tb;

  // about 400 strobes plus 30 locks with clears and field reads, with margin
  localparam int watchdog_time = 200000;
  localparam int busy_limit    = 2000;

  logic                  clk;
  logic                  rst;
  logic                  start_i;
  logic                  right_i;
  logic                  left_i;
  logic                  ror_i;
  logic                  rol_i;
  logic                  down_i;
  logic                  disp_rd_i;
  tetris_pkg::row_addr_t disp_addr_i;
  logic                  disp_valid_o;
  tetris_pkg::row_t      disp_data_o;
  tetris_pkg::piece_t    piece_o;
  tetris_pkg::rot_t      rot_o;
  tetris_pkg::row_addr_t row_o;
  tetris_pkg::col_t      col_o;
  logic                  busy_o;
  logic                  game_over_o;
  logic [15:0]           lines_o;

  int errors;
  int seed;

  // reference model state
  int grid [22][10];
  int m_piece, m_rot, m_row, m_col, m_ctr, m_lines, m_over;

  tetris_top #(.spawn_col(3)) uut (
    .clk, .rst, .start_i, .right_i, .left_i, .ror_i, .rol_i, .down_i, .disp_rd_i,
    .disp_addr_i, .disp_valid_o, .disp_data_o, .piece_o, .rot_o, .row_o, .col_o,
    .busy_o, .game_over_o, .lines_o
  );

  always #4 clk = ~clk;

  initial begin
    #(watchdog_time);
    $display("watchdog expired, the run did not finish in time");
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // cell (r,c) of the 3x3 corner goes to (c, 2-r)
  function automatic bit [15:0] rotate_cw(input bit [15:0] m);
    bit [15:0] res;
    res = '0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        if (m[r*4+c]) res[c*4+(2-r)] = 1'b1;
      end
    end
    return res;
  endfunction

  function automatic bit [15:0] shape_of(input int p, input int rot);
    bit [15:0] m;
    case (p)
      0: m = (rot == 0) ? 16'h00F0 : (rot == 1) ? 16'h4444 :
             (rot == 2) ? 16'h0F00 : 16'h2222;
      1: m = 16'h0066;
      2: m = 16'h0072;
      3: m = 16'h0036;
      4: m = 16'h0063;
      5: m = 16'h0071;
      default: m = 16'h0074;
    endcase
    if (p >= 2) begin
      for (int i = 0; i < rot; i++) m = rotate_cw(m);
    end
    return m;
  endfunction

  function automatic bit fits(input int p, input int rot, input int row, input int col);
    bit [15:0] m;
    m = shape_of(p, rot);
    for (int i = 0; i < 16; i++) begin
      if (m[i]) begin
        if (col + i % 4 < 0 || col + i % 4 > 9 || row + i / 4 > 21) return 1'b0;
        if (grid[row + i / 4][col + i % 4] != 0) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic model_spawn();
    int p;
    p = m_ctr;
    m_ctr = (m_ctr + 1) % 7;
    if (fits(p, 0, 0, 3)) begin
      m_piece = p;
      m_rot = 0;
      m_row = 0;
      m_col = 3;
    end else begin
      m_over = 1;
    end
  endtask

  task automatic model_lock();
    bit [15:0] m;
    int w, full, n;
    m = shape_of(m_piece, m_rot);
    for (int i = 0; i < 16; i++) begin
      if (m[i]) grid[m_row + i / 4][m_col + i % 4] = m_piece + 1;
    end
    // compact bottom-up
    w = 21;
    n = 0;
    for (int r = 21; r >= 0; r--) begin
      full = 1;
      for (int c = 0; c < 10; c++) if (grid[r][c] == 0) full = 0;
      if (full) begin
        n++;
      end else begin
        for (int c = 0; c < 10; c++) grid[w][c] = grid[r][c];
        w--;
      end
    end
    for (int r = w; r >= 0; r--) begin
      for (int c = 0; c < 10; c++) grid[r][c] = 0;
    end
    m_lines += n;
    model_spawn();
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks and DUT access
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_state();
    check_val("piece_o", int'(piece_o), m_piece);
    check_val("rot_o", int'(rot_o), m_rot);
    check_val("row_o", int'(row_o), m_row);
    check_val("col_o", int'(col_o), m_col);
    check_val("lines_o", int'(lines_o), m_lines);
    check_val("game_over_o", int'(game_over_o), m_over);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o && n < busy_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (busy_o) begin
      errors++;
      $display("busy_o stayed high for %0d cycles at %0t", busy_limit, $time);
    end
  endtask

  task automatic compare_field();
    tetris_pkg::row_t exp;
    int n;
    for (int r = 0; r < 22; r++) begin
      for (int c = 0; c < 10; c++) exp[c] = grid[r][c][2:0];
      disp_rd_i = 1'b1;
      disp_addr_i = r[4:0];
      n = 0;
      @(posedge clk);
      #1;
      disp_rd_i = 1'b0;
      while (!disp_valid_o && n < 20) begin
        @(posedge clk);
        #1;
        n++;
      end
      if (!disp_valid_o) begin
        errors++;
        $display("display read of row %0d got no valid at %0t", r, $time);
      end else if (disp_data_o !== exp) begin
        errors++;
        $display("mismatch at %0t: disp_data_o row %0d got %h expected %h",
                 $time, r, disp_data_o, exp);
      end
    end
  endtask

  // move codes 0 right, 1 left, 2 ror, 3 rol, 4 down
  task automatic apply_move(input int mv);
    int nrot, nrow, ncol;
    case (mv)
      0: right_i = 1'b1;
      1: left_i = 1'b1;
      2: ror_i = 1'b1;
      3: rol_i = 1'b1;
      default: down_i = 1'b1;
    endcase
    @(posedge clk);
    #1;
    {right_i, left_i, ror_i, rol_i, down_i} = '0;
    wait_idle();
    if (m_over) begin
      check_state();
      return;
    end
    nrot = m_rot;
    nrow = m_row;
    ncol = m_col;
    case (mv)
      0: ncol++;
      1: ncol--;
      2: nrot = (nrot + 1) % 4;
      3: nrot = (nrot + 3) % 4;
      default: nrow++;
    endcase
    if (fits(m_piece, nrot, nrow, ncol)) begin
      m_rot = nrot;
      m_row = nrow;
      m_col = ncol;
      check_state();
    end else if (mv == 4) begin
      model_lock();
      check_state();
      compare_field();
    end else begin
      check_state();
    end
  endtask

  task automatic start_game();
    start_i = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
    wait_idle();
    foreach (grid[r, c]) grid[r][c] = 0;
    m_lines = 0;
    m_over = 0;
    model_spawn();
    check_state();
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    m_ctr = 0;
    m_over = 0;
  endtask

  // drop until the piece locks
  task automatic drop_piece();
    int p0;
    p0 = m_ctr;
    while (m_ctr == p0 && !m_over) apply_move(4);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic after_start();
    reset_dut();
    start_game();
    check_val("piece_o", int'(piece_o), 0);
    check_val("col_o", int'(col_o), 3);
    compare_field();
  endtask

  task automatic wall_stops();
    repeat (6) apply_move(0);
    check_val("col_o", int'(col_o), 6);
    repeat (9) apply_move(1);
    check_val("col_o", int'(col_o), 0);
    repeat (3) apply_move(0);
  endtask

  task automatic rotation_steps();
    repeat (5) apply_move(2);
    repeat (3) apply_move(3);
    // bar upright against the right wall, then turned
    apply_move(3);
    repeat (8) apply_move(0);
    apply_move(2);
    apply_move(3);
    check_val("rot_o", int'(rot_o), 1);
  endtask

  task automatic drop_and_spawn();
    drop_piece();
    check_val("piece_o", int'(piece_o), 1);
    drop_piece();
    check_val("piece_o", int'(piece_o), 2);
  endtask

  task automatic line_clears();
    reset_dut();
    start_game();
    // I to the left, O in the middle, T to the right, S upright into the gap
    repeat (3) apply_move(1);
    drop_piece();
    drop_piece();
    repeat (3) apply_move(0);
    drop_piece();
    apply_move(2);
    repeat (4) apply_move(0);
    drop_piece();
    if (lines_o < 1) begin
      errors++;
      $display("scripted sequence cleared no line at %0t", $time);
    end
    for (int i = 0; i < 60; i++) apply_move({$random(seed)} % 5);
  endtask

  task automatic game_over_restart();
    int n;
    reset_dut();
    start_game();
    n = 0;
    while (!m_over && n < 40) begin
      drop_piece();
      n++;
    end
    check_val("game_over_o", int'(game_over_o), 1);
    start_game();
    compare_field();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    {start_i, right_i, left_i, ror_i, rol_i, down_i, disp_rd_i} = '0;
    disp_addr_i = '0;
    errors = 0;
    seed = 32'h3975_63d7;
    foreach (grid[r, c]) grid[r][c] = 0;
    {m_piece, m_rot, m_row, m_col, m_ctr, m_lines, m_over} = '0;
    after_start();
    wall_stops();
    rotation_steps();
    drop_and_spawn();
    line_clears();
    game_over_restart();
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
design/tetris_pkg.sv
design/playfield_mem.sv
design/row_arbiter.sv
design/collision_checker.sv
design/piece_stamper.sv
design/line_clearer.sv
design/game_ctrl.sv
design/tetris_top.sv
verif/tetris_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tetris_tb -f src.f -o tetris_sim

./obj_dir/tetris_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
  exit 0
fi
exit 1
